// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // one data or instruction word
  typedef logic [15:0] word_t;
  // imem address at the default depth of 256 words
  typedef logic [7:0] pc_t;
  // eight general registers
  typedef logic [2:0] reg_addr_t;
  typedef logic [3:0] shamt_t;
  // condition codes, indexed below
  typedef logic [2:0] ccr_t;

  localparam int CCR_Z = 0;
  localparam int CCR_N = 1;
  localparam int CCR_C = 2;

  // unlisted codes run as nop
  typedef enum logic [4:0] {
    OP_NOP = 5'd0,
    OP_ADD = 5'd1,
    OP_SUB = 5'd2,
    OP_AND = 5'd3,
    OP_OR  = 5'd4,
    OP_NOT = 5'd5,
    OP_MOV = 5'd6,
    OP_SHL = 5'd7,
    OP_SHR = 5'd8,
    OP_IN  = 5'd9,
    OP_OUT = 5'd10,
    OP_LDM = 5'd11,
    OP_HLT = 5'd31
  } opcode_t;

  // fetch control
  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_ACTIVE,
    RUN_STOPPED
  } run_state_t;

  // instruction field extraction
  function automatic opcode_t instr_op(word_t w);
    return opcode_t'(w[15:11]);
  endfunction

  function automatic reg_addr_t instr_rd(word_t w);
    return w[10:8];
  endfunction

  function automatic reg_addr_t instr_rs(word_t w);
    return w[7:5];
  endfunction

  function automatic reg_addr_t instr_rt(word_t w);
    return w[4:2];
  endfunction

  // shifts only, overlaps rt
  function automatic shamt_t instr_shamt(word_t w);
    return w[3:0];
  endfunction

endpackage

`default_nettype wire

// ==== decode_exec_if.sv ====
`default_nettype none

// one decoded operation, decode to execute
interface decode_exec_if;
  import cpu_pkg::*;

  // single-cycle strobe, no ready
  logic      valid;
  opcode_t   op;
  // a from rs, b from rt
  word_t     a;
  word_t     b;
  shamt_t    shamt;
  reg_addr_t rd;
  // ldm immediate
  word_t     imm;

  modport producer (
    output valid, op, a, b, shamt, rd, imm
  );

  modport consumer (
    input valid, op, a, b, shamt, rd, imm
  );

endinterface

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
  parameter int IMEM_AW = 8
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               start,
  input  wire logic               imem_we,
  input  wire logic [IMEM_AW-1:0] imem_addr,
  input  wire cpu_pkg::word_t     imem_wdata,
  input  wire logic               hlt_decoded,
  output      logic               instr_valid,
  output      cpu_pkg::word_t     instr
);
  import cpu_pkg::*;

  // program store, loaded before start
  word_t              imem [2**IMEM_AW];
  logic [IMEM_AW-1:0] pc;
  run_state_t         state;

  // load port and synchronous read
  always_ff @(posedge clk)
  begin
    if (imem_we)
    begin
      imem[imem_addr] <= imem_wdata;
    end
    // word shows one cycle after its address
    instr <= imem[pc];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state       <= RUN_IDLE;
      pc          <= '0;
      instr_valid <= 1'b0;
    end
    else
    begin
      case (state)
        RUN_IDLE:
        begin
          instr_valid <= 1'b0;
          if (start)
          begin
            // address 0 goes out next cycle
            state <= RUN_ACTIVE;
            pc    <= '0;
          end
        end
        RUN_ACTIVE:
        begin
          if (hlt_decoded)
          begin
            // drop the word read at this edge
            state       <= RUN_STOPPED;
            instr_valid <= 1'b0;
          end
          else
          begin
            instr_valid <= 1'b1;
            pc          <= pc + 1'b1;
          end
        end
        default:
        begin
          // stays stopped until reset
          instr_valid <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none

module decode_stage (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                instr_valid,
  input  wire cpu_pkg::word_t      instr,
  input  wire logic                wb_en,
  input  wire cpu_pkg::reg_addr_t  wb_addr,
  input  wire cpu_pkg::word_t      wb_data,
  output      logic                hlt_decoded,
  decode_exec_if.producer          dx
);
  import cpu_pkg::*;

  word_t     rf [8];
  // set after an ldm word, cleared by its immediate
  logic      ldm_pending;
  reg_addr_t ldm_rd;

  opcode_t   op;
  reg_addr_t rd;
  reg_addr_t rs;
  reg_addr_t rt;
  word_t     rs_val;
  word_t     rt_val;

  // field split
  always_comb
  begin
    op = instr_op(instr);
    rd = instr_rd(instr);
    rs = instr_rs(instr);
    rt = instr_rt(instr);
  end

  // operand read, bypassing the result now in execute
  always_comb
  begin
    rs_val = rf[rs];
    rt_val = rf[rt];
    if (wb_en && (wb_addr == rs))
    begin
      rs_val = wb_data;
    end
    if (wb_en && (wb_addr == rt))
    begin
      rt_val = wb_data;
    end
  end

  // an ldm immediate may look like hlt, so skip it
  assign hlt_decoded = instr_valid && !ldm_pending && (op == OP_HLT);

  // register file write from execute
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
      begin
        rf[i] <= '0;
      end
    end
    else if (wb_en)
    begin
      rf[wb_addr] <= wb_data;
    end
  end

  // strobe and ldm pairing
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      dx.valid    <= 1'b0;
      ldm_pending <= 1'b0;
    end
    else if (!instr_valid)
    begin
      dx.valid <= 1'b0;
    end
    else if (ldm_pending)
    begin
      // immediate word completes the ldm
      dx.valid    <= 1'b1;
      ldm_pending <= 1'b0;
    end
    else if (op == OP_LDM)
    begin
      // first half, nothing issued yet
      dx.valid    <= 1'b0;
      ldm_pending <= 1'b1;
    end
    else
    begin
      dx.valid <= 1'b1;
    end
  end

  // operation payload
  always_ff @(posedge clk)
  begin
    if (instr_valid)
    begin
      if (ldm_pending)
      begin
        dx.op  <= OP_LDM;
        dx.rd  <= ldm_rd;
        dx.imm <= instr;
      end
      else
      begin
        dx.op    <= op;
        dx.rd    <= rd;
        dx.a     <= rs_val;
        dx.b     <= rt_val;
        dx.shamt <= instr_shamt(instr);
        // hold target for the word that follows
        ldm_rd   <= rd;
      end
    end
  end

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
`default_nettype none

module execute_unit (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire cpu_pkg::word_t      in_port,
  decode_exec_if.consumer          dx,
  output      logic                wb_en,
  output      cpu_pkg::reg_addr_t  wb_addr,
  output      cpu_pkg::word_t      wb_data,
  output      cpu_pkg::word_t      out_port,
  output      logic                out_valid,
  output      cpu_pkg::ccr_t       ccr,
  output      logic                halted
);
  import cpu_pkg::*;

  word_t        result;
  logic         carry;
  logic         writes_rd;
  logic         sets_flags;
  // 17-bit view so carry falls out of the top
  logic [16:0]  wide;
  ccr_t         next_ccr;

  // alu
  always_comb
  begin
    result     = '0;
    carry      = 1'b0;
    writes_rd  = 1'b0;
    sets_flags = 1'b0;
    wide       = '0;
    case (dx.op)
      OP_ADD:
      begin
        wide       = {1'b0, dx.a} + {1'b0, dx.b};
        result     = wide[15:0];
        carry      = wide[16];
        writes_rd  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_SUB:
      begin
        result     = dx.a - dx.b;
        // borrow
        carry      = dx.a < dx.b;
        writes_rd  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_AND:
      begin
        result     = dx.a & dx.b;
        writes_rd  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_OR:
      begin
        result     = dx.a | dx.b;
        writes_rd  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_NOT:
      begin
        result     = ~dx.a;
        writes_rd  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_MOV:
      begin
        result    = dx.a;
        writes_rd = 1'b1;
      end
      OP_SHL:
      begin
        // last bit out of the top, zero for shamt 0
        wide       = {1'b0, dx.a} << dx.shamt;
        result     = wide[15:0];
        carry      = wide[16];
        writes_rd  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_SHR:
      begin
        // last bit out of the bottom lands in bit 0
        wide       = {dx.a, 1'b0} >> dx.shamt;
        result     = wide[16:1];
        carry      = wide[0];
        writes_rd  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_IN:
      begin
        result    = in_port;
        writes_rd = 1'b1;
      end
      OP_LDM:
      begin
        result    = dx.imm;
        writes_rd = 1'b1;
      end
      default:
      begin
        // nop, out, hlt and unused codes
        result = '0;
      end
    endcase
  end

  always_comb
  begin
    next_ccr        = '0;
    next_ccr[CCR_Z] = (result == '0);
    next_ccr[CCR_N] = result[15];
    next_ccr[CCR_C] = carry;
  end

  // write-back also feeds decode forwarding
  assign wb_en   = dx.valid && writes_rd;
  assign wb_addr = dx.rd;
  assign wb_data = result;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ccr       <= '0;
      out_valid <= 1'b0;
      out_port  <= '0;
      halted    <= 1'b0;
    end
    else
    begin
      if (dx.valid && sets_flags)
      begin
        ccr <= next_ccr;
      end
      // port strobe one cycle behind the out op
      out_valid <= dx.valid && (dx.op == OP_OUT);
      if (dx.valid && (dx.op == OP_OUT))
      begin
        out_port <= dx.a;
      end
      // sticky until reset
      if (dx.valid && (dx.op == OP_HLT))
      begin
        halted <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`default_nettype none

module cpu_top #(
  parameter int IMEM_AW = $bits(cpu_pkg::pc_t)
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               start,
  input  wire logic               imem_we,
  input  wire logic [IMEM_AW-1:0] imem_addr,
  input  wire cpu_pkg::word_t     imem_wdata,
  input  wire cpu_pkg::word_t     in_port,
  output      cpu_pkg::word_t     out_port,
  output      logic               out_valid,
  output      cpu_pkg::ccr_t      ccr,
  output      logic               halted
);
  import cpu_pkg::*;

  // fetch to decode
  logic      instr_valid;
  word_t     instr;
  logic      hlt_decoded;

  // execute write-back, also the bypass source
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  decode_exec_if dx_if ();

  fetch_unit #(
    .IMEM_AW (IMEM_AW)
  ) i_fetch (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .hlt_decoded (hlt_decoded),
    .instr_valid (instr_valid),
    .instr       (instr)
  );

  decode_stage i_decode (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .hlt_decoded (hlt_decoded),
    .dx          (dx_if.producer)
  );

  execute_unit i_execute (
    .clk       (clk),
    .rst       (rst),
    .in_port   (in_port),
    .dx        (dx_if.consumer),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .out_port  (out_port),
    .out_valid (out_valid),
    .ccr       (ccr),
    .halted    (halted)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  // free-running, starts low
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(PERIOD / 2);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`default_nettype none

module tb_cpu;
  import cpu_pkg::*;

  localparam int NUM_PROGS  = 8;
  localparam int MIN_OPS    = 20;
  localparam int MAX_OPS    = 40;
  // filler words placed after hlt
  localparam int TAIL_WORDS = 4;
  // every op may be an ldm pair, plus hlt and filler
  localparam int MAX_WORDS  = 2 * MAX_OPS + 1 + TAIL_WORDS;
  localparam int CLK_PERIOD = 10;
  // reset, load, run and drain per program, with margin
  localparam int WATCHDOG_TIME = NUM_PROGS * (2 * MAX_WORDS + 40) * CLK_PERIOD;

  logic  clk;
  logic  rst;
  logic  start;
  logic  imem_we;
  pc_t   imem_addr;
  word_t imem_wdata;
  word_t in_port;
  word_t out_port;
  logic  out_valid;
  ccr_t  ccr;
  logic  halted;

  // current program image
  word_t prog [MAX_WORDS];
  int    prog_len;
  word_t in_val;
  // model results
  word_t exp_out [$];
  int    exp_out_count;
  ccr_t  exp_ccr;
  int    errors;

  tb_clock_gen #(
    .PERIOD (CLK_PERIOD)
  ) i_clk (
    .clk (clk)
  );

  cpu_top #(
    .IMEM_AW ($bits(pc_t))
  ) i_dut (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .in_port    (in_port),
    .out_port   (out_port),
    .out_valid  (out_valid),
    .ccr        (ccr),
    .halted     (halted)
  );

  task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // inputs change 1 unit after the rising edge
  task automatic next_drive_slot();
    @(posedge clk);
    #1;
  endtask

  // nothing may come out before start
  task automatic check_quiet();
    @(negedge clk);
    compare_value("out_valid", 32'd0, 32'(out_valid));
    compare_value("halted", 32'd0, 32'(halted));
  endtask

  // out is weighted so most programs print often
  function automatic opcode_t pick_opcode();
    int unsigned r;
    r = $urandom % 16;
    case (r)
      0:       return OP_NOP;
      1:       return OP_ADD;
      2:       return OP_SUB;
      3:       return OP_AND;
      4:       return OP_OR;
      5:       return OP_NOT;
      6:       return OP_MOV;
      7:       return OP_SHL;
      8:       return OP_SHR;
      9:       return OP_IN;
      10:      return OP_LDM;
      11:      return OP_LDM;
      default: return OP_OUT;
    endcase
  endfunction

  task automatic build_program();
    int      n_ops;
    opcode_t op;
    n_ops    = MIN_OPS + int'($urandom % (MAX_OPS - MIN_OPS + 1));
    prog_len = 0;
    for (int i = 0; i < n_ops; i++)
    begin
      op = pick_opcode();
      // last op always prints something
      if (i == n_ops - 1)
      begin
        op = OP_OUT;
      end
      prog[prog_len] = {op, 11'($urandom)};
      prog_len = prog_len + 1;
      if (op == OP_LDM)
      begin
        prog[prog_len] = word_t'($urandom);
        prog_len = prog_len + 1;
      end
    end
    prog[prog_len] = {OP_HLT, 11'($urandom)};
    prog_len = prog_len + 1;
    // out ops after hlt must never run
    for (int i = 0; i < TAIL_WORDS; i++)
    begin
      prog[prog_len] = {OP_OUT, 11'($urandom)};
      prog_len = prog_len + 1;
    end
  endtask

  // in-order instruction model over the program image
  task automatic run_model();
    word_t       regs [8];
    int          pc;
    logic [4:0]  op;
    logic [2:0]  rd;
    word_t       a;
    word_t       b;
    word_t       r;
    word_t       tmp;
    logic [3:0]  s;
    logic [16:0] sum;
    logic        c;
    logic        wr;
    logic        sets;
    logic        done;
    for (int i = 0; i < 8; i++)
    begin
      regs[i] = '0;
    end
    exp_out.delete();
    exp_out_count = 0;
    exp_ccr = '0;
    pc   = 0;
    done = 1'b0;
    while (!done && (pc < prog_len))
    begin
      op   = prog[pc][15:11];
      rd   = prog[pc][10:8];
      a    = regs[prog[pc][7:5]];
      b    = regs[prog[pc][4:2]];
      s    = prog[pc][3:0];
      r    = '0;
      c    = 1'b0;
      wr   = 1'b0;
      sets = 1'b0;
      pc   = pc + 1;
      case (op)
        OP_ADD:
        begin
          sum  = {1'b0, a} + {1'b0, b};
          r    = sum[15:0];
          c    = sum[16];
          wr   = 1'b1;
          sets = 1'b1;
        end
        OP_SUB:
        begin
          r    = a - b;
          c    = (a < b);
          wr   = 1'b1;
          sets = 1'b1;
        end
        OP_AND:
        begin
          r    = a & b;
          wr   = 1'b1;
          sets = 1'b1;
        end
        OP_OR:
        begin
          r    = a | b;
          wr   = 1'b1;
          sets = 1'b1;
        end
        OP_NOT:
        begin
          r    = ~a;
          wr   = 1'b1;
          sets = 1'b1;
        end
        OP_MOV:
        begin
          r  = a;
          wr = 1'b1;
        end
        OP_SHL:
        begin
          r    = a << s;
          // bit 16-s is the last to leave the top
          tmp  = a >> (16 - int'(s));
          c    = (s == 4'd0) ? 1'b0 : tmp[0];
          wr   = 1'b1;
          sets = 1'b1;
        end
        OP_SHR:
        begin
          r    = a >> s;
          tmp  = a >> (int'(s) - 1);
          c    = (s == 4'd0) ? 1'b0 : tmp[0];
          wr   = 1'b1;
          sets = 1'b1;
        end
        OP_IN:
        begin
          r  = in_val;
          wr = 1'b1;
        end
        OP_OUT:
        begin
          exp_out.push_back(a);
          exp_out_count++;
        end
        OP_LDM:
        begin
          // immediate is the next word
          r  = prog[pc];
          pc = pc + 1;
          wr = 1'b1;
        end
        OP_HLT:
        begin
          done = 1'b1;
        end
        default:
        begin
          r = '0;
        end
      endcase
      if (wr)
      begin
        regs[rd] = r;
      end
      if (sets)
      begin
        exp_ccr[CCR_Z] = (r == 16'd0);
        exp_ccr[CCR_N] = r[15];
        exp_ccr[CCR_C] = c;
      end
    end
  endtask

  task automatic run_program();
    int   seen;
    logic halt_seen;
    next_drive_slot();
    rst     = 1'b1;
    start   = 1'b0;
    imem_we = 1'b0;
    in_port = in_val;
    repeat (2)
    begin
      next_drive_slot();
    end
    rst = 1'b0;
    // load port, one word per cycle
    for (int i = 0; i < prog_len; i++)
    begin
      imem_we    = 1'b1;
      imem_addr  = pc_t'(i);
      imem_wdata = prog[i];
      check_quiet();
      next_drive_slot();
    end
    imem_we = 1'b0;
    start   = 1'b1;
    next_drive_slot();
    start = 1'b0;
    seen      = 0;
    halt_seen = 1'b0;
    while (!halt_seen)
    begin
      @(negedge clk);
      if (out_valid)
      begin
        seen++;
        assert (exp_out.size() > 0)
        else
        begin
          $display("out_valid strobe at %0t with no expected value left", $time);
          errors++;
        end
        if (exp_out.size() > 0)
        begin
          compare_value("out_port", 32'(exp_out.pop_front()), 32'(out_port));
        end
      end
      if (halted)
      begin
        halt_seen = 1'b1;
      end
    end
    compare_value("ccr", 32'(exp_ccr), 32'(ccr));
    compare_value("out_count", 32'(exp_out_count), 32'(seen));
    // quiet and sticky after halt
    repeat (10)
    begin
      @(negedge clk);
      compare_value("out_valid", 32'd0, 32'(out_valid));
      compare_value("halted", 32'd1, 32'(halted));
    end
  endtask

  initial
  begin
    errors     = 0;
    rst        = 1'b1;
    start      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    in_port    = '0;
    in_val     = '0;
    void'($urandom(32'h03bf0ab3));
    for (int p = 0; p < NUM_PROGS; p++)
    begin
      build_program();
      in_val = word_t'($urandom);
      run_model();
      run_program();
    end
    $display("summary: %0d errors over %0d programs", errors, NUM_PROGS);
    if (errors == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

  // hard stop if halted never arrives
  initial
  begin
    #(WATCHDOG_TIME);
    $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
cpu_pkg.sv
decode_exec_if.sv
fetch_unit.sv
decode_stage.sv
execute_unit.sv
cpu_top.sv
tb_clock_gen.sv
tb_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
set -u

cd "$(dirname "$0")"

if ! verilator --binary --timing --assert -f project.f --top-module tb_cpu \
    -o tb_cpu_sim > build.log 2>&1; then
  echo "build failed, see build.log"
  exit 1
fi

if ! ./obj_dir/tb_cpu_sim > sim.log 2>&1; then
  echo "simulator exited with an error, see sim.log"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

echo "simulation clean, see sim.log"
exit 0
